/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := ex_tb
FILELIST  := list.f

SOURCES := $(shell cat $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

/* list.f */
logic/ex_pkg.sv
logic/ex_issue_queue.sv
logic/ex_regfile.sv
logic/ex_operand_stage.sv
logic/ex_alu.sv
logic/ex_branch_unit.sv
logic/ex_cluster_top.sv
sim/ex_tb.sv

/* logic/ex_alu.sv */
module ex_alu (
    input   wire logic                  cpu_clock_i,
    input   wire logic                  arst_n_i,
    input   wire ex_pkg::dispatch_t     disp_i,
    output       ex_pkg::result_t       result_o
);
    logic [31:0] value;
    logic [4:0]  shamt;

    assign shamt = disp_i.b[4:0];

    always_comb begin
        case (disp_i.op.alu_view)
            ex_pkg::ALU_ADD:  value = disp_i.a + disp_i.b;
            ex_pkg::ALU_SUB:  value = disp_i.a - disp_i.b;
            ex_pkg::ALU_AND:  value = disp_i.a & disp_i.b;
            ex_pkg::ALU_OR:   value = disp_i.a | disp_i.b;
            ex_pkg::ALU_XOR:  value = disp_i.a ^ disp_i.b;
            ex_pkg::ALU_SLL:  value = disp_i.a << shamt;
            ex_pkg::ALU_SRL:  value = disp_i.a >> shamt;
            ex_pkg::ALU_SRA:  value = $unsigned($signed(disp_i.a) >>> shamt);
            ex_pkg::ALU_SLT:  value = {31'b0, $signed(disp_i.a) < $signed(disp_i.b)};
            ex_pkg::ALU_SLTU: value = {31'b0, disp_i.a < disp_i.b};
            default:          value = '0;
        endcase
    end

    always_ff @(posedge cpu_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_o <= '0;
        end else begin
            result_o.valid  <= disp_i.valid && (disp_i.op_class == ex_pkg::CLS_ALU);
            result_o.dest   <= disp_i.dest;
            result_o.rob_id <= disp_i.rob_id;
            result_o.value  <= value;
        end
    end

endmodule

/* logic/ex_branch_unit.sv */
module ex_branch_unit (
    input   wire logic                  cpu_clock_i,
    input   wire logic                  arst_n_i,
    input   wire ex_pkg::dispatch_t     disp_i,
    input   wire ex_pkg::result_t       alu_result_i,
    output       ex_pkg::result_t       br_result_o,
    output       ex_pkg::result_t       result_o,
    output       ex_pkg::redirect_t     redirect_o
);
    logic [31:0] pc_byte;
    logic [31:0] link;
    logic [31:0] jalr_sum;
    logic [31:0] value;
    logic [31:0] target;
    logic        cond_true;
    logic        taken;
    logic        is_br;
    logic        mispredict;

    assign pc_byte  = {disp_i.pc, 2'b00};
    assign link     = pc_byte + 32'd4;
    assign jalr_sum = disp_i.a + disp_i.imm;
    assign is_br    = disp_i.valid && (disp_i.op_class != ex_pkg::CLS_ALU);

    always_comb begin
        case (disp_i.op.br_view.cond)
            ex_pkg::BR_BEQ:  cond_true = disp_i.a == disp_i.b;
            ex_pkg::BR_BNE:  cond_true = disp_i.a != disp_i.b;
            ex_pkg::BR_BLT:  cond_true = $signed(disp_i.a) < $signed(disp_i.b);
            ex_pkg::BR_BGE:  cond_true = $signed(disp_i.a) >= $signed(disp_i.b);
            ex_pkg::BR_BLTU: cond_true = disp_i.a < disp_i.b;
            ex_pkg::BR_BGEU: cond_true = disp_i.a >= disp_i.b;
            default:         cond_true = 1'b0;
        endcase
    end

    always_comb begin
        value  = link;
        taken  = 1'b0;
        target = link; // Fall-through.
        case (disp_i.op_class)
            ex_pkg::CLS_LUI:   value = disp_i.imm;
            ex_pkg::CLS_AUIPC: value = pc_byte + disp_i.imm;
            ex_pkg::CLS_JAL: begin
                taken  = 1'b1;
                target = pc_byte + disp_i.imm;
            end
            ex_pkg::CLS_JALR: begin
                taken  = 1'b1;
                target = {jalr_sum[31:1], 1'b0};
            end
            ex_pkg::CLS_BRANCH: begin
                value = '0;
                taken = cond_true;
                if (cond_true) target = pc_byte + disp_i.imm;
            end
            default: value = '0;
        endcase
    end

    // JALR has no predicted target, so it always redirects.
    assign mispredict = (disp_i.op_class == ex_pkg::CLS_JALR)
                      || (((disp_i.op_class == ex_pkg::CLS_JAL)
                          || (disp_i.op_class == ex_pkg::CLS_BRANCH))
                          && (taken != disp_i.pred_taken));

    always_ff @(posedge cpu_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            br_result_o <= '0;
            redirect_o  <= '0;
        end else begin
            br_result_o.valid  <= is_br && ex_pkg::has_result(disp_i.op_class, disp_i.dest);
            br_result_o.dest   <= disp_i.dest;
            br_result_o.rob_id <= disp_i.rob_id;
            br_result_o.value  <= value;
            redirect_o.valid   <= is_br && mispredict;
            redirect_o.target  <= target[31:2];
        end
    end

    assign result_o = br_result_o.valid ? br_result_o : alu_result_i;

endmodule

/* logic/ex_cluster_top.sv */
module ex_cluster_top #(
    parameter int QUEUE_DEPTH = 4,
    parameter int OUT_CREDITS = 2
) (
    input   wire logic                  cpu_clock_i,
    input   wire logic                  arst_n_i,
    input   wire ex_pkg::instr_t        instr_i,
    input   wire logic                  issue_valid_i,
    output       logic                  credit_o,
    input   wire logic                  result_credit_i,
    output       ex_pkg::result_t       result_o,
    output       ex_pkg::redirect_t     redirect_o
);
    ex_pkg::instr_t     head;
    logic               head_valid;
    logic               pop;
    ex_pkg::tag_t       rd_tag_a;
    ex_pkg::tag_t       rd_tag_b;
    logic [31:0]        rd_data_a;
    logic [31:0]        rd_data_b;
    ex_pkg::dispatch_t  disp;
    ex_pkg::result_t    alu_result;
    ex_pkg::result_t    br_result;

    ex_issue_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue_i (
        .cpu_clock_i, .arst_n_i,
        .push_i(issue_valid_i), .instr_i, .pop_i(pop), .flush_i(redirect_o.valid),
        .head_o(head), .head_valid_o(head_valid), .credit_o
    );

    ex_regfile regfile_i (
        .cpu_clock_i, .arst_n_i,
        .rd_tag_a_i(rd_tag_a), .rd_tag_b_i(rd_tag_b),
        .rd_data_a_o(rd_data_a), .rd_data_b_o(rd_data_b),
        .wr_a_i(alu_result), .wr_b_i(br_result)
    );

    ex_operand_stage #(.OUT_CREDITS(OUT_CREDITS)) operand_i (
        .cpu_clock_i, .arst_n_i, .flush_i(redirect_o.valid),
        .head_i(head), .head_valid_i(head_valid), .pop_o(pop),
        .rd_tag_a_o(rd_tag_a), .rd_tag_b_o(rd_tag_b),
        .rd_data_a_i(rd_data_a), .rd_data_b_i(rd_data_b),
        .bypass_i(result_o), .result_credit_i, .disp_o(disp)
    );

    ex_alu alu_i (
        .cpu_clock_i, .arst_n_i, .disp_i(disp), .result_o(alu_result)
    );

    ex_branch_unit branch_i (
        .cpu_clock_i, .arst_n_i, .disp_i(disp), .alu_result_i(alu_result),
        .br_result_o(br_result), .result_o, .redirect_o
    );

endmodule

/* logic/ex_issue_queue.sv */
module ex_issue_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input   wire logic              cpu_clock_i,
    input   wire logic              arst_n_i,
    input   wire logic              push_i,
    input   wire ex_pkg::instr_t    instr_i,
    input   wire logic              pop_i,
    input   wire logic              flush_i,
    output       ex_pkg::instr_t    head_o,
    output       logic              head_valid_o,
    output       logic              credit_o
);
    localparam int AW = $clog2(QUEUE_DEPTH);
    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    ex_pkg::instr_t     mem [QUEUE_DEPTH];
    logic [AW-1:0]      rd_ptr;
    logic [AW-1:0]      wr_ptr;
    logic [CW-1:0]      count;
    logic [CW-1:0]      drop_cnt;   // Flushed entries whose credit is still owed.
    logic [CW-1:0]      drop_next;
    logic               push_fire;
    logic               pop_fire;

    // The head is held back until every flushed credit has gone out.
    assign head_valid_o = (count != '0) && (drop_cnt == '0);
    assign head_o       = mem[rd_ptr];
    assign push_fire    = push_i && !flush_i;
    assign pop_fire     = pop_i && head_valid_o && !flush_i;
    assign credit_o     = pop_fire || (drop_cnt != '0);

    always_comb begin
        drop_next = drop_cnt;
        if (drop_cnt != '0) begin
            drop_next = drop_cnt - 1'b1;
        end
        if (flush_i) begin
            drop_next = drop_next + count + CW'(push_i); // A push in the flush cycle is dropped too.
        end
    end

    always_ff @(posedge cpu_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            drop_cnt <= '0;
        end else begin
            drop_cnt <= drop_next;
            if (flush_i) begin
                rd_ptr <= wr_ptr;
                count  <= '0;
            end else begin
                if (push_fire) wr_ptr <= wr_ptr + 1'b1;
                if (pop_fire)  rd_ptr <= rd_ptr + 1'b1;
                count <= count + CW'(push_fire) - CW'(pop_fire);
            end
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (push_fire) mem[wr_ptr] <= instr_i;
    end

    // The issuer holds a credit for every slot it fills, dropped ones included.
    a_push_with_credit: assert property (@(posedge cpu_clock_i) disable iff (!arst_n_i)
        push_i |-> (int'(count) + int'(drop_cnt)) < QUEUE_DEPTH);

    a_pop_not_empty: assert property (@(posedge cpu_clock_i) disable iff (!arst_n_i)
        pop_i |-> head_valid_o);

endmodule

/* logic/ex_operand_stage.sv */
module ex_operand_stage #(
    parameter int OUT_CREDITS = 2
) (
    input   wire logic                  cpu_clock_i,
    input   wire logic                  arst_n_i,
    input   wire logic                  flush_i,
    input   wire ex_pkg::instr_t        head_i,
    input   wire logic                  head_valid_i,
    output       logic                  pop_o,
    output       ex_pkg::tag_t          rd_tag_a_o,
    output       ex_pkg::tag_t          rd_tag_b_o,
    input   wire logic [31:0]           rd_data_a_i,
    input   wire logic [31:0]           rd_data_b_i,
    input   wire ex_pkg::result_t       bypass_i,
    input   wire logic                  result_credit_i,
    output       ex_pkg::dispatch_t     disp_o
);
    localparam int CW = $clog2(OUT_CREDITS + 1);

    logic [31:0]        op_a;
    logic [31:0]        op_rs2;
    logic               hazard;
    logic               needs_credit;
    logic               dispatch;
    logic               refund;
    logic [CW-1:0]      credit_cnt;
    logic               disp_valid_q;
    ex_pkg::dispatch_t  disp_pay_q;

    assign rd_tag_a_o = head_i.rs1;
    assign rd_tag_b_o = head_i.rs2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operands and bypass.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign op_a   = (bypass_i.valid && (bypass_i.dest == head_i.rs1) && (head_i.rs1 != '0))
                  ? bypass_i.value : rd_data_a_i;
    assign op_rs2 = (bypass_i.valid && (bypass_i.dest == head_i.rs2) && (head_i.rs2 != '0))
                  ? bypass_i.value : rd_data_b_i;

    // A source written by the instruction now in the units waits one cycle for the bypass.
    assign hazard = disp_valid_q && (disp_pay_q.dest != '0)
                  && ex_pkg::has_result(disp_pay_q.op_class, disp_pay_q.dest)
                  && ((disp_pay_q.dest == head_i.rs1) || (disp_pay_q.dest == head_i.rs2));

    assign needs_credit = ex_pkg::has_result(head_i.op_class, head_i.dest);
    assign dispatch     = head_valid_i && !flush_i && !hazard && (credit_cnt != '0);
    assign pop_o        = dispatch;

    // The wrong-path instruction killed by a flush gives its credit back.
    assign refund = flush_i && disp_valid_q
                  && ex_pkg::has_result(disp_pay_q.op_class, disp_pay_q.dest);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output credits and dispatch register.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge cpu_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_cnt   <= CW'(OUT_CREDITS);
            disp_valid_q <= 1'b0;
        end else begin
            credit_cnt   <= credit_cnt + CW'(result_credit_i) + CW'(refund)
                          - CW'(dispatch && needs_credit);
            disp_valid_q <= dispatch;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (dispatch) begin
            disp_pay_q.valid      <= 1'b1;
            disp_pay_q.op_class   <= head_i.op_class;
            disp_pay_q.op         <= head_i.op;
            disp_pay_q.dest       <= head_i.dest;
            disp_pay_q.rob_id     <= head_i.rob_id;
            disp_pay_q.a          <= op_a;
            disp_pay_q.b          <= head_i.imm_sel ? head_i.imm : op_rs2;
            disp_pay_q.imm        <= head_i.imm;
            disp_pay_q.pc         <= head_i.pc;
            disp_pay_q.pred_taken <= head_i.pred_taken;
        end
    end

    always_comb begin
        disp_o       = disp_pay_q;
        disp_o.valid = disp_valid_q && !flush_i; // Units ignore the slot during a flush.
    end

    a_credit_bound: assert property (@(posedge cpu_clock_i) disable iff (!arst_n_i)
        int'(credit_cnt) <= OUT_CREDITS);

endmodule

/* logic/ex_pkg.sv */
package ex_pkg;

    typedef logic [5:0] tag_t;     // Tag 0 reads as zero.
    typedef logic [4:0] rob_id_t;

    typedef enum logic [2:0] {
        CLS_ALU    = 3'd0,
        CLS_JAL    = 3'd1,
        CLS_JALR   = 3'd2,
        CLS_LUI    = 3'd3,
        CLS_AUIPC  = 3'd4,
        CLS_BRANCH = 3'd5
    } op_class_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    // Branch conditions keep the funct3 encoding.
    typedef enum logic [2:0] {
        BR_BEQ  = 3'd0,
        BR_BNE  = 3'd1,
        BR_BLT  = 3'd4,
        BR_BGE  = 3'd5,
        BR_BLTU = 3'd6,
        BR_BGEU = 3'd7
    } br_cond_e;

    typedef struct packed {
        logic     spare;
        br_cond_e cond;
    } br_view_t;

    // The same four bits are an ALU operation or a branch condition.
    typedef union packed {
        alu_op_e  alu_view;
        br_view_t br_view;
    } op_u;

    typedef struct packed {
        op_class_e   op_class;
        op_u         op;
        logic        imm_sel;   // Operand b takes the immediate.
        tag_t        rs1;
        tag_t        rs2;
        tag_t        dest;
        rob_id_t     rob_id;
        logic [31:0] imm;
        logic [29:0] pc;        // Word address.
        logic        pred_taken;
    } instr_t;

    typedef struct packed {
        logic        valid;
        op_class_e   op_class;
        op_u         op;
        tag_t        dest;
        rob_id_t     rob_id;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [29:0] pc;
        logic        pred_taken;
    } dispatch_t;

    typedef struct packed {
        logic        valid;
        tag_t        dest;
        rob_id_t     rob_id;
        logic [31:0] value;
    } result_t;

    typedef struct packed {
        logic        valid;
        logic [29:0] target;
    } redirect_t;

    // Conditional branches and jumps without a link register write nothing back.
    function automatic logic has_result(op_class_e op_class, tag_t dest);
        case (op_class)
            CLS_BRANCH:        return 1'b0;
            CLS_JAL, CLS_JALR: return dest != '0;
            default:           return 1'b1;
        endcase
    endfunction

endpackage

/* logic/ex_regfile.sv */
module ex_regfile (
    input   wire logic                  cpu_clock_i,
    input   wire logic                  arst_n_i,
    input   wire ex_pkg::tag_t          rd_tag_a_i,
    input   wire ex_pkg::tag_t          rd_tag_b_i,
    output       logic [31:0]           rd_data_a_o,
    output       logic [31:0]           rd_data_b_o,
    input   wire ex_pkg::result_t       wr_a_i,
    input   wire ex_pkg::result_t       wr_b_i
);
    logic [31:0] regs [64];

    // Entry 0 is never written, so it reads back zero.
    assign rd_data_a_o = regs[rd_tag_a_i];
    assign rd_data_b_o = regs[rd_tag_b_i];

    always_ff @(posedge cpu_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 64; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr_a_i.valid && (wr_a_i.dest != '0)) begin
                regs[wr_a_i.dest] <= wr_a_i.value;
            end
            if (wr_b_i.valid && (wr_b_i.dest != '0)) begin
                regs[wr_b_i.dest] <= wr_b_i.value;
            end
        end
    end

    // One instruction dispatches per cycle, so the ALU and branch unit never finish together.
    a_single_writer: assert property (@(posedge cpu_clock_i) disable iff (!arst_n_i)
        !(wr_a_i.valid && wr_b_i.valid));

endmodule

/* sim/ex_tb.sv */
module ex_tb;

    localparam int QUEUE_DEPTH = 4;
    localparam int OUT_CREDITS = 2;
    localparam int FIELDS      = 15;     // Words per record in the data file.
    localparam int MAX_RECORDS = 64;

    logic               cpu_clock_i;
    logic               arst_n_i;
    logic               issue_valid_i;
    logic               result_credit_i;
    logic               credit_o;
    ex_pkg::instr_t     instr_i;
    ex_pkg::result_t    result_o;
    ex_pkg::redirect_t  redirect_o;

    logic [31:0]        tests [FIELDS*MAX_RECORDS];
    int                 n_records;
    int                 in_credits;
    int                 credit_prev;
    int                 pending;     // Results seen but not yet credited back.
    logic               stalled;
    ex_pkg::result_t    exp_results [$];
    logic [29:0]        exp_targets [$];

    ex_cluster_top #(.QUEUE_DEPTH(QUEUE_DEPTH), .OUT_CREDITS(OUT_CREDITS)) dut_i (
        .cpu_clock_i, .arst_n_i, .instr_i, .issue_valid_i, .credit_o,
        .result_credit_i, .result_o, .redirect_o
    );

    always #5 cpu_clock_i = ~cpu_clock_i;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output monitor.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic observe();
        ex_pkg::result_t exp_r;
        logic [29:0]     exp_t;
        in_credits  += credit_prev;  // A returned credit is usable one cycle after its pulse.
        credit_prev  = int'(credit_o);
        if (in_credits > QUEUE_DEPTH) begin
            fail_run("issue credits returned beyond the queue depth");
        end
        if (result_o.valid) begin
            if (exp_results.size() == 0) begin
                fail_run("a result arrived with no instruction outstanding");
            end else begin
                exp_r = exp_results.pop_front();
                check_value("result_o.dest", {26'b0, result_o.dest}, {26'b0, exp_r.dest});
                check_value("result_o.rob_id", {27'b0, result_o.rob_id}, {27'b0, exp_r.rob_id});
                check_value("result_o.value", result_o.value, exp_r.value);
                pending++;
                if (pending > OUT_CREDITS) fail_run("more results than output credits");
            end
        end
        if (redirect_o.valid) begin
            if (exp_targets.size() == 0) begin
                fail_run("a redirect appeared for a correctly predicted instruction");
            end else begin
                exp_t = exp_targets.pop_front();
                check_value("redirect_o.target", {2'b0, redirect_o.target}, {2'b0, exp_t});
            end
        end
    endtask

    task automatic step();
        @(negedge cpu_clock_i);
        observe();
        issue_valid_i = 1'b0;
        if (!stalled && (pending > 0)) begin
            result_credit_i = 1'b1;
            pending--;
        end else begin
            result_credit_i = 1'b0;
        end
    endtask

    function automatic logic idle();
        return (exp_results.size() == 0) && (exp_targets.size() == 0)
            && (in_credits + credit_prev == QUEUE_DEPTH) && (pending == 0);
    endfunction

    task automatic issue_record(input int base);
        ex_pkg::result_t exp_r;
        while (in_credits == 0) step();
        instr_i.op_class     = ex_pkg::op_class_e'(tests[base+1][2:0]);
        instr_i.op.alu_view  = ex_pkg::alu_op_e'(tests[base+2][3:0]);
        instr_i.imm_sel      = tests[base+3][0];
        instr_i.rs1          = tests[base+4][5:0];
        instr_i.rs2          = tests[base+5][5:0];
        instr_i.dest         = tests[base+6][5:0];
        instr_i.rob_id       = tests[base+7][4:0];
        instr_i.imm          = tests[base+8];
        instr_i.pc           = tests[base+9][29:0];
        instr_i.pred_taken   = tests[base+10][0];
        issue_valid_i        = 1'b1;
        in_credits--;
        if (tests[base+11][0]) begin
            exp_r.valid  = 1'b1;
            exp_r.dest   = instr_i.dest;
            exp_r.rob_id = instr_i.rob_id;
            exp_r.value  = tests[base+12];
            exp_results.push_back(exp_r);
        end
        if (tests[base+13][0]) exp_targets.push_back(tests[base+14][29:0]);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int base;
        cpu_clock_i     = 1'b0;
        arst_n_i        = 1'b0;
        issue_valid_i   = 1'b0;
        result_credit_i = 1'b0;
        instr_i         = '0;
        stalled         = 1'b0;
        pending         = 0;
        credit_prev     = 0;
        in_credits      = QUEUE_DEPTH;
        for (int i = 0; i < FIELDS*MAX_RECORDS; i++) begin
            tests[i] = 32'hf;  // Mode f marks the end of the records.
        end
        $readmemh("sim/ex_tests.mem", tests);
        n_records = 0;
        while ((n_records < MAX_RECORDS) && (tests[n_records*FIELDS] != 32'hf)) n_records++;

        repeat (5) begin
            @(negedge cpu_clock_i);
            check_value("credit_o", {31'b0, credit_o}, 32'h0);
            check_value("result_o.valid", {31'b0, result_o.valid}, 32'h0);
            check_value("redirect_o.valid", {31'b0, redirect_o.valid}, 32'h0);
        end
        arst_n_i = 1'b1;

        for (int r = 0; r < n_records; r++) begin
            base = r * FIELDS;
            step();
            case (tests[base])
                32'h0:   issue_record(base);
                32'h1:   stalled = 1'b1;
                32'h2: begin
                    // Withheld credits let exactly OUT_CREDITS results through.
                    check_value("result_o.valid count", pending, OUT_CREDITS);
                    stalled = 1'b0;
                end
                32'h3:   while (!idle()) step();
                default: fail_run("unknown mode word in the test file");
            endcase
        end
        step();
        while (!idle()) step();
        // A few more cycles catch any stray result, redirect or credit.
        repeat (4) step();
        if (!idle()) begin
            fail_run("results or credits still outstanding at the end");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

    initial begin
        @(posedge arst_n_i);
        repeat (20*n_records + 100) @(posedge cpu_clock_i);
        fail_run("watchdog expired before the tests finished");
    end

endmodule

/* sim/ex_tests.mem */
// mode(0 issue 1 stall 2 grant 3 wait) class op imm_sel rs1 rs2 dest rob imm pc pred
// then exp_result exp_value exp_redirect exp_target
0 0 0 1 28 00 01 00 00000000 000 0 1 00000000 0 000
0 0 0 1 00 00 00 01 00000005 000 0 1 00000005 0 000
0 0 0 1 00 00 02 02 00000000 000 0 1 00000000 0 000
0 3 0 0 00 00 03 03 12345000 000 0 1 12345000 0 000
0 0 0 1 03 00 04 04 00000678 000 0 1 12345678 0 000
0 0 0 1 00 00 05 05 fffffff0 000 0 1 fffffff0 0 000
0 0 0 1 00 00 06 06 00000004 000 0 1 00000004 0 000
0 0 1 0 04 06 07 07 00000000 000 0 1 12345674 0 000
0 0 2 0 04 05 08 08 00000000 000 0 1 12345670 0 000
0 0 3 0 04 06 09 09 00000000 000 0 1 1234567c 0 000
0 0 4 0 04 05 0a 0a 00000000 000 0 1 edcba988 0 000
0 0 5 0 04 06 0b 0b 00000000 000 0 1 23456780 0 000
0 0 6 0 05 06 0c 0c 00000000 000 0 1 0fffffff 0 000
0 0 7 0 05 06 0d 0d 00000000 000 0 1 ffffffff 0 000
0 0 8 0 05 06 0e 0e 00000000 000 0 1 00000001 0 000
0 0 9 0 05 06 0f 0f 00000000 000 0 1 00000000 0 000
0 0 0 0 0f 0e 10 10 00000000 000 0 1 00000001 0 000
0 4 0 0 00 00 11 11 00000010 100 0 1 00000410 0 000
0 5 0 0 06 06 00 12 00000020 100 1 0 00000000 0 000
0 5 1 0 06 06 00 13 00000020 100 1 0 00000000 1 101
3 0 0 0 00 00 00 00 00000000 000 0 0 00000000 0 000
0 5 0 0 05 06 00 14 00000020 100 0 0 00000000 0 000
0 5 4 0 05 06 00 15 00000020 100 0 0 00000000 1 108
3 0 0 0 00 00 00 00 00000000 000 0 0 00000000 0 000
0 5 5 0 05 06 00 16 00000020 100 0 0 00000000 0 000
0 5 6 0 05 06 00 17 00000020 100 1 0 00000000 1 101
3 0 0 0 00 00 00 00 00000000 000 0 0 00000000 0 000
0 5 7 0 05 06 00 18 00000020 100 1 0 00000000 0 000
0 1 0 0 00 00 1b 19 00000040 100 1 1 00000404 0 000
0 2 0 0 06 00 1c 1a 00000101 100 1 1 00000404 1 041
3 0 0 0 00 00 00 00 00000000 000 0 0 00000000 0 000
0 5 0 0 05 06 00 1b 00000020 100 1 0 00000000 1 101
0 0 0 1 00 00 1d 1c 00000007 000 0 0 00000000 0 000
0 0 0 1 00 00 1e 1d 00000008 000 0 0 00000000 0 000
3 0 0 0 00 00 00 00 00000000 000 0 0 00000000 0 000
1 0 0 0 00 00 00 00 00000000 000 0 0 00000000 0 000
0 0 0 1 00 00 20 1e 00000001 000 0 1 00000001 0 000
0 0 0 1 00 00 21 1f 00000002 000 0 1 00000002 0 000
0 0 0 1 00 00 22 00 00000003 000 0 1 00000003 0 000
0 0 0 1 00 00 23 01 00000004 000 0 1 00000004 0 000
0 0 0 1 00 00 24 02 00000005 000 0 1 00000005 0 000
0 0 0 1 00 00 25 03 00000006 000 0 1 00000006 0 000
2 0 0 0 00 00 00 00 00000000 000 0 0 00000000 0 000
3 0 0 0 00 00 00 00 00000000 000 0 0 00000000 0 000
